//--- rtl/bc_isa_pkg.sv
package bc_isa_pkg;

    localparam int PC_W      = 16;  // byte address into program memory
    localparam int WORD_W    = 32;  // int width, operand stack and locals
    localparam int LV_ADDR_W = 8;   // local-variable array address

    // jvm encodings of the supported subset
    typedef enum logic [7:0] {
        ICONST_0     = 8'h03,
        ICONST_1     = 8'h04,
        ICONST_2     = 8'h05,
        ICONST_3     = 8'h06,
        ICONST_4     = 8'h07,
        ICONST_5     = 8'h08,
        BIPUSH       = 8'h10,
        LDC          = 8'h12,
        ILOAD        = 8'h15,
        ISTORE       = 8'h36,
        IADD         = 8'h60,
        ISUB         = 8'h64,
        IFEQ         = 8'h99,
        GOTO         = 8'ha7,
        IRETURN      = 8'hac,
        RETURN       = 8'hb1,
        INVOKESTATIC = 8'hb8
    } opcode_e;

    // bytes taken by an instruction, opcode included
    function automatic logic [1:0] op_len(opcode_e op);
        case (op)
            BIPUSH, LDC, ILOAD, ISTORE: return 2'd2;  // one operand byte
            GOTO, IFEQ, INVOKESTATIC:   return 2'd3;  // 16-bit operand
            default:                    return 2'd1;
        endcase
    endfunction

endpackage

//--- rtl/bc_frame_pkg.sv
package bc_frame_pkg;

    // call stack entry, one per active invocation
    typedef struct packed {
        logic [bc_isa_pkg::PC_W-1:0]      ret_pc;   // address after the invoke
        logic [bc_isa_pkg::LV_ADDR_W-1:0] lv_base;  // caller's local-variable base
        logic [7:0]                       pad;
    } frame_t;

    // constant-pool word describing a static method
    typedef struct packed {
        logic [15:0] code_addr;    // bits 31..16
        logic [7:0]  arg_count;    // bits 15..8
        logic [7:0]  local_count;  // bits 7..0, args included
    } method_desc_t;

endpackage

//--- rtl/store_if.sv
`timescale 1ns/1ns

interface store_if #(
    parameter type payload_t = logic [31:0],
    parameter int  ADDR_W    = 8
) ();

    logic              req;    // held high until ack is seen
    logic              write;  // push on a stack, store on a ram
    logic [ADDR_W-1:0] addr;   // ignored by stacks
    payload_t          wdata;
    payload_t          rdata;  // valid while ack is high
    logic              ack;    // dropped once req falls

    modport requester (output req, write, addr, wdata, input rdata, ack);
    modport responder (input req, write, addr, wdata, output rdata, ack);

endinterface

//--- rtl/local_var_array.sv
`timescale 1ns/1ns

module local_var_array #(
    parameter int WORDS = 256
) (
    input  logic       clk,
    input  logic       rst,
    store_if.responder port
);

    logic [bc_isa_pkg::WORD_W-1:0] mem [WORDS];  // locals of every live frame
    logic start;                                 // req seen while idle

    assign start = port.req && !port.ack;

    // handshake side
    always_ff @(posedge clk) begin
        if (rst) begin
            port.ack <= 1'b0;
        end else if (start) begin
            port.ack <= 1'b1;  // access done this edge
        end else if (!port.req && port.ack) begin
            port.ack <= 1'b0;  // requester let go
        end
    end

    // one access per request, on the req edge
    always_ff @(posedge clk) begin
        if (start) begin
            if (port.write) begin
                mem[port.addr] <= port.wdata;
                port.rdata     <= port.wdata;  // echo the stored word
            end else begin
                port.rdata <= mem[port.addr];
            end
        end
    end

endmodule

//--- rtl/lifo_stack.sv
`timescale 1ns/1ns

module lifo_stack #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    store_if.responder                 port,   // write means push
    output logic [$clog2(DEPTH+1)-1:0] depth   // entries held
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [CW-1:0] below;  // slot of the current top
    logic          start;  // first cycle of a request
    logic          full;
    logic          empty;

    assign below = depth - 1'b1;
    assign start = port.req && !port.ack;
    assign full  = depth == CW'(DEPTH);
    assign empty = depth == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            port.ack <= 1'b0;
            depth    <= '0;
        end else if (start) begin
            port.ack <= 1'b1;
            if (port.write && !full) begin
                depth <= depth + 1'b1;
            end else if (!port.write && !empty) begin
                depth <= below;
            end  // overflow or underflow is acked but changes nothing
        end else if (!port.req && port.ack) begin
            port.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start && port.write && !full) begin
            mem[depth[AW-1:0]] <= port.wdata;
        end
        if (start && !port.write && !empty) begin
            port.rdata <= mem[below[AW-1:0]];  // else rdata keeps the last value
        end
    end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [7:0]                          op_code,
    input  logic [7:0]                          arg1,
    input  logic [7:0]                          arg2,
    input  logic [bc_isa_pkg::WORD_W-1:0]       dataparams,
    input  logic                                call_busy,    // sequencer owns this opcode
    input  logic [bc_isa_pkg::LV_ADDR_W-1:0]    lv_base,
    store_if.requester                          op,           // operand stack
    store_if.requester                          lv,           // local variables
    input  logic                                pop_req,      // argument pop for an invoke
    output logic                                pop_ack,
    output logic [bc_isa_pkg::WORD_W-1:0]       pop_data,
    output logic                                op_done,
    output logic signed [bc_isa_pkg::PC_W-1:0]  next_offset,
    output logic [bc_isa_pkg::WORD_W-1:0]       top_value     // last word pushed or popped
);

    localparam int W = bc_isa_pkg::WORD_W;

    typedef enum logic [2:0] {
        S_IDLE, S_LDC, S_POP_A, S_POP_B, S_LV, S_PUSH, S_DONE, S_SVC
    } state_e;

    state_e              state;
    bc_isa_pkg::opcode_e opc;
    logic [W-1:0]        a;         // first pop, the old stack top
    logic [W-1:0]        wval;      // word waiting to be pushed
    logic [1:0]          wait_cnt;  // pool latency for ldc
    logic                op_go;     // operand stack ready for a new req
    logic                op_fin;    // operand handshake completes
    logic                lv_go;
    logic                lv_fin;

    assign opc     = bc_isa_pkg::opcode_e'(op_code);
    assign op_go   = !op.req && !op.ack;
    assign op_fin  = op.req && op.ack;
    assign lv_go   = !lv.req && !lv.ack;
    assign lv_fin  = lv.req && lv.ack;
    assign op_done = state == S_DONE;  // one cycle, pc moves on this edge

    assign op.write = state == S_PUSH;
    assign op.addr  = '0;
    assign op.wdata = wval;
    assign lv.write = opc == bc_isa_pkg::ISTORE;
    assign lv.addr  = lv_base + arg1;  // frame relative index
    assign lv.wdata = a;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            op.req      <= 1'b0;
            lv.req      <= 1'b0;
            pop_ack     <= 1'b0;
            top_value   <= '0;
            next_offset <= '0;
            wait_cnt    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    next_offset <= bc_isa_pkg::PC_W'(bc_isa_pkg::op_len(opc));
                    if (pop_ack) begin
                        pop_ack <= pop_req;  // hold until the sequencer lets go
                    end else if (pop_req) begin
                        state <= S_SVC;
                    end else if (!call_busy) begin
                        case (opc)
                            bc_isa_pkg::ICONST_0, bc_isa_pkg::ICONST_1,
                            bc_isa_pkg::ICONST_2, bc_isa_pkg::ICONST_3,
                            bc_isa_pkg::ICONST_4, bc_isa_pkg::ICONST_5: begin
                                wval  <= W'(op_code - 8'(bc_isa_pkg::ICONST_0));
                                state <= S_PUSH;
                            end
                            bc_isa_pkg::BIPUSH: begin
                                wval  <= {{(W-8){arg1[7]}}, arg1};  // sign extend
                                state <= S_PUSH;
                            end
                            bc_isa_pkg::LDC: begin
                                wait_cnt <= '0;
                                state    <= S_LDC;
                            end
                            bc_isa_pkg::ILOAD: state <= S_LV;
                            bc_isa_pkg::ISTORE, bc_isa_pkg::IFEQ,
                            bc_isa_pkg::IADD, bc_isa_pkg::ISUB: state <= S_POP_A;
                            bc_isa_pkg::GOTO: begin
                                next_offset <= {arg1, arg2};
                                state       <= S_DONE;
                            end
                            default: state <= S_IDLE;  // invoke and returns
                        endcase
                    end
                end
                S_LDC: begin  // dataindex moves, pool word follows a cycle later
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == 2'd2) begin
                        wval  <= dataparams;
                        state <= S_PUSH;
                    end
                end
                S_POP_A: begin
                    if (op_go) begin
                        op.req <= 1'b1;
                    end
                    if (op_fin) begin
                        op.req    <= 1'b0;
                        a         <= op.rdata;
                        top_value <= op.rdata;
                        if (opc == bc_isa_pkg::ISTORE) begin
                            state <= S_LV;
                        end else if (opc == bc_isa_pkg::IFEQ) begin
                            if (op.rdata == '0) begin
                                next_offset <= {arg1, arg2};  // taken
                            end
                            state <= S_DONE;
                        end else begin
                            state <= S_POP_B;
                        end
                    end
                end
                S_POP_B: begin
                    if (op_go) begin
                        op.req <= 1'b1;
                    end
                    if (op_fin) begin
                        op.req    <= 1'b0;
                        top_value <= op.rdata;
                        // second pop is the left operand, wraps at 32 bits
                        wval  <= (opc == bc_isa_pkg::ISUB) ? op.rdata - a : op.rdata + a;
                        state <= S_PUSH;
                    end
                end
                S_LV: begin
                    if (lv_go) begin
                        lv.req <= 1'b1;
                    end
                    if (lv_fin) begin
                        lv.req <= 1'b0;
                        wval   <= lv.rdata;
                        state  <= (opc == bc_isa_pkg::ILOAD) ? S_PUSH : S_DONE;
                    end
                end
                S_PUSH: begin
                    if (op_go) begin
                        op.req <= 1'b1;
                    end
                    if (op_fin) begin
                        op.req    <= 1'b0;
                        top_value <= wval;
                        state     <= S_DONE;
                    end
                end
                S_SVC: begin  // pop on behalf of the sequencer
                    if (op_go) begin
                        op.req <= 1'b1;
                    end
                    if (op_fin) begin
                        op.req    <= 1'b0;
                        pop_data  <= op.rdata;
                        top_value <= op.rdata;
                        pop_ack   <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;  // S_DONE
            endcase
        end
    end

endmodule

//--- rtl/method_sequencer.sv
`timescale 1ns/1ns

module method_sequencer #(
    parameter int CALLSTACK_DEPTH = 16
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [7:0]                               op_code,
    input  logic [7:0]                               arg1,
    input  logic [7:0]                               arg2,
    input  logic [bc_isa_pkg::WORD_W-1:0]            dataparams,
    input  logic                                     op_done,
    input  logic signed [bc_isa_pkg::PC_W-1:0]       next_offset,
    store_if.requester                               call,        // call stack
    store_if.requester                               lv,          // argument writes
    output logic                                     lv_own,
    output logic                                     pop_req,
    input  logic                                     pop_ack,
    input  logic [bc_isa_pkg::WORD_W-1:0]            pop_data,
    output logic [bc_isa_pkg::LV_ADDR_W-1:0]         lv_base,
    output logic                                     call_busy,
    output logic [15:0]                              dataindex,
    output logic [bc_isa_pkg::PC_W-1:0]              program_counter,
    output logic                                     halted,
    input  logic [$clog2(CALLSTACK_DEPTH+1)-1:0]     call_depth
);

    localparam logic [7:0] MAIN_LOCALS = 8'd16;  // frame size of the entry method

    typedef enum logic [2:0] {
        S_RUN, S_DWAIT, S_DESC, S_POP, S_LVW, S_PUSH, S_RET, S_HALT
    } state_e;

    state_e                             state;
    bc_isa_pkg::opcode_e                opc;
    bc_frame_pkg::method_desc_t         desc_in;   // pool word as a descriptor
    bc_frame_pkg::method_desc_t         desc;      // callee being entered
    bc_frame_pkg::frame_t               frame_in;
    bc_frame_pkg::frame_t               frame_out;
    logic [7:0]                         cur_locals;  // locals of the running method
    logic [7:0]                         argn;        // args left to move
    logic [bc_isa_pkg::LV_ADDR_W-1:0]   new_base;
    logic [bc_isa_pkg::WORD_W-1:0]      argv;

    assign opc       = bc_isa_pkg::opcode_e'(op_code);
    assign desc_in   = bc_frame_pkg::method_desc_t'(dataparams);
    assign frame_in  = call.rdata;
    assign call_busy = state != S_RUN;
    assign halted    = state == S_HALT;
    assign lv_own    = state == S_LVW;

    // return point is past the invoke, opcode still on the bus here
    assign frame_out.ret_pc  = program_counter + bc_isa_pkg::PC_W'(bc_isa_pkg::op_len(opc));
    assign frame_out.lv_base = lv_base;
    assign frame_out.pad     = '0;
    assign call.write        = state == S_PUSH;
    assign call.addr         = '0;
    assign call.wdata        = frame_out;

    assign lv.write = 1'b1;
    assign lv.addr  = new_base + argn;  // last arg lands in the highest slot
    assign lv.wdata = argv;

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= S_RUN;
            program_counter <= '0;
            dataindex       <= '0;
            lv_base         <= '0;
            cur_locals      <= MAIN_LOCALS;
            pop_req         <= 1'b0;
            lv.req          <= 1'b0;
            call.req        <= 1'b0;
        end else begin
            case (state)
                S_RUN: begin
                    if (op_done) begin
                        program_counter <= program_counter + next_offset;
                    end else if (opc == bc_isa_pkg::LDC) begin
                        dataindex <= {8'h00, arg1};
                    end else if (opc == bc_isa_pkg::INVOKESTATIC) begin
                        dataindex <= {arg1, arg2};
                        state     <= S_DWAIT;
                    end else if (opc == bc_isa_pkg::IRETURN || opc == bc_isa_pkg::RETURN) begin
                        state <= (call_depth == '0) ? S_HALT : S_RET;
                    end
                end
                S_DWAIT: state <= S_DESC;  // descriptor arrives next cycle
                S_DESC: begin
                    desc     <= desc_in;
                    argn     <= desc_in.arg_count;
                    new_base <= lv_base + cur_locals;  // callee frame above the caller's
                    state    <= (desc_in.arg_count == '0) ? S_PUSH : S_POP;
                end
                S_POP: begin
                    if (!pop_req && !pop_ack) begin
                        pop_req <= 1'b1;
                    end
                    if (pop_req && pop_ack) begin
                        pop_req <= 1'b0;
                        argv    <= pop_data;
                        argn    <= argn - 1'b1;
                        state   <= S_LVW;
                    end
                end
                S_LVW: begin
                    if (!lv.req && !lv.ack) begin
                        lv.req <= 1'b1;
                    end
                    if (lv.req && lv.ack) begin
                        lv.req <= 1'b0;
                        state  <= (argn == '0) ? S_PUSH : S_POP;
                    end
                end
                S_PUSH: begin
                    if (!call.req && !call.ack) begin
                        call.req <= 1'b1;
                    end
                    if (call.req && call.ack) begin  // frame saved, enter callee
                        call.req        <= 1'b0;
                        lv_base         <= new_base;
                        cur_locals      <= desc.local_count;
                        program_counter <= desc.code_addr;
                        state           <= S_RUN;
                    end
                end
                S_RET: begin  // ireturn value stays on the operand stack
                    if (!call.req && !call.ack) begin
                        call.req <= 1'b1;
                    end
                    if (call.req && call.ack) begin
                        call.req        <= 1'b0;
                        program_counter <= frame_in.ret_pc;
                        lv_base         <= frame_in.lv_base;
                        cur_locals      <= lv_base - frame_in.lv_base;  // caller frame size
                        state           <= S_RUN;
                    end
                end
                default: state <= S_HALT;  // stays until reset
            endcase
        end
    end

endmodule

//--- rtl/bc_core.sv
`timescale 1ns/1ns

module bc_core #(
    parameter int OPSTACK_DEPTH   = 32,
    parameter int CALLSTACK_DEPTH = 16,
    parameter int LV_WORDS        = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  op_code,          // program memory, same cycle as pc
    input  logic [7:0]  arg1,
    input  logic [7:0]  arg2,
    input  logic [31:0] dataparams,       // constant pool, a cycle after dataindex
    output logic [15:0] dataindex,
    output logic [15:0] program_counter,
    output logic [31:0] result,
    output logic        halted
);

    localparam int W  = bc_isa_pkg::WORD_W;
    localparam int LA = bc_isa_pkg::LV_ADDR_W;

    logic                                    lv_own;       // sequencer holds the locals
    logic                                    call_busy;
    logic                                    pop_req;
    logic                                    pop_ack;
    logic [W-1:0]                            pop_data;
    logic                                    op_done;
    logic signed [bc_isa_pkg::PC_W-1:0]      next_offset;
    logic [LA-1:0]                           lv_base;
    logic [$clog2(CALLSTACK_DEPTH+1)-1:0]    call_depth;

    store_if #(.payload_t(logic [W-1:0]), .ADDR_W(1))  op_if ();
    store_if #(.payload_t(logic [W-1:0]), .ADDR_W(LA)) lv_x_if ();  // exec side
    store_if #(.payload_t(logic [W-1:0]), .ADDR_W(LA)) lv_s_if ();  // sequencer side
    store_if #(.payload_t(logic [W-1:0]), .ADDR_W(LA)) lv_if ();    // to the ram
    store_if #(.payload_t(bc_frame_pkg::frame_t), .ADDR_W(1)) call_if ();

    // local-variable port goes to whoever the sequencer says
    assign lv_if.req     = lv_own ? lv_s_if.req   : lv_x_if.req;
    assign lv_if.write   = lv_own ? lv_s_if.write : lv_x_if.write;
    assign lv_if.addr    = lv_own ? lv_s_if.addr  : lv_x_if.addr;
    assign lv_if.wdata   = lv_own ? lv_s_if.wdata : lv_x_if.wdata;
    assign lv_x_if.rdata = lv_if.rdata;
    assign lv_s_if.rdata = lv_if.rdata;
    assign lv_x_if.ack   = lv_if.ack && !lv_own;
    assign lv_s_if.ack   = lv_if.ack && lv_own;

    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2), .dataparams(dataparams),
        .call_busy(call_busy), .lv_base(lv_base),
        .op(op_if.requester), .lv(lv_x_if.requester),
        .pop_req(pop_req), .pop_ack(pop_ack), .pop_data(pop_data),
        .op_done(op_done), .next_offset(next_offset), .top_value(result)
    );

    method_sequencer #(.CALLSTACK_DEPTH(CALLSTACK_DEPTH)) u_seq (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2), .dataparams(dataparams),
        .op_done(op_done), .next_offset(next_offset),
        .call(call_if.requester), .lv(lv_s_if.requester), .lv_own(lv_own),
        .pop_req(pop_req), .pop_ack(pop_ack), .pop_data(pop_data),
        .lv_base(lv_base), .call_busy(call_busy), .dataindex(dataindex),
        .program_counter(program_counter), .halted(halted), .call_depth(call_depth)
    );

    local_var_array #(.WORDS(LV_WORDS)) u_lva (
        .clk(clk), .rst(rst), .port(lv_if.responder)
    );

    lifo_stack #(.payload_t(logic [W-1:0]), .DEPTH(OPSTACK_DEPTH)) u_opstack (
        .clk(clk), .rst(rst), .port(op_if.responder), .depth()
    );

    lifo_stack #(.payload_t(bc_frame_pkg::frame_t), .DEPTH(CALLSTACK_DEPTH)) u_callstack (
        .clk(clk), .rst(rst), .port(call_if.responder), .depth(call_depth)
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 8
) (
    input  logic rearm,  // restart the reset window for the next test
    output logic clk,
    output logic rst
);

    int   left = RST_CYCLES;  // reset cycles still to go
    logic again;

    initial clk = 1'b0;
    initial rst = 1'b1;

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        again = rearm;  // sampled on the edge, driven after it
        #1;
        if (again) begin
            left = RST_CYCLES;
        end else if (left > 0) begin
            left = left - 1;
        end
        rst = left != 0;
    end

endmodule

//--- dv/bc_core_tb.sv
`timescale 1ns/1ns

module bc_core_tb;

    localparam int CYCLES_PER_TEST = 2000;

    logic        clk;
    logic        rst;
    logic        rearm = 1'b0;
    logic [7:0]  op_code;
    logic [7:0]  arg1;
    logic [7:0]  arg2;
    logic [31:0] dataparams = '0;
    logic [15:0] dataindex;
    logic [15:0] program_counter;
    logic [31:0] result;
    logic        halted;

    logic [31:0] vec [1024];   // flat word image of the vectors file
    logic [7:0]  prog [256];   // program memory of the running test
    logic [31:0] pool [256];   // constant pool of the running test
    logic [7:0]  held = '0;    // pool index seen on the last edge
    int          cycles = 0;
    int          cycle_limit = 0;
    string       cur_name = "startup";
    logic [15:0] prev_pc = '0;
    logic [7:0]  prev_op = '0;
    logic [7:0]  prev_arg1 = '0;

    tb_clock #(.PERIOD(40), .RST_CYCLES(8)) u_clock (
        .rearm(rearm), .clk(clk), .rst(rst)
    );

    bc_core u_dut (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2),
        .dataparams(dataparams), .dataindex(dataindex),
        .program_counter(program_counter), .result(result), .halted(halted)
    );

    // program memory answers in the same cycle
    assign op_code = prog[program_counter[7:0]];
    assign arg1    = prog[8'(program_counter + 16'd1)];
    assign arg2    = prog[8'(program_counter + 16'd2)];

    // constant pool lags dataindex by one cycle
    always @(posedge clk) begin
        #1;
        dataparams = pool[held];
        held       = dataindex[7:0];
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
            stop_run();
        end
    endtask

    function automatic string test_name(int num);
        case (num)
            1:       return "const_arith";
            2:       return "locals";
            3:       return "const_pool";
            4:       return "countdown_loop";
            5:       return "invoke";
            6:       return "nested_invoke";
            default: return $sformatf("test_%0d", num);
        endcase
    endfunction

    // global watchdog, limit scales with the number of tests
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout in %s, the core never halted within %0d cycles",
                     cur_name, cycle_limit);
            stop_run();
        end
    end

    // an ldc has retired when the pc moves off it
    always @(negedge clk) begin
        if (!rst && program_counter !== prev_pc && prev_op == 8'h12) begin
            check_value({cur_name, " dataindex"}, {24'h0, prev_arg1}, {16'h0, dataindex});
        end
        prev_pc   = program_counter;
        prev_op   = op_code;
        prev_arg1 = arg1;
    end

    initial begin
        int p;
        int n;
        int num;
        int ntests;
        logic [31:0] expected;

        for (int i = 0; i < 1024; i++) vec[i] = '0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = '0;
            pool[i] = '0;
        end
        $readmemh("dv/bc_core_vectors.hex", vec);

        // first walk only counts records for the watchdog
        p      = 0;
        ntests = 0;
        while (vec[p] != 0 && p < 1000) begin
            p      = p + 2 + vec[p + 1];  // number, byte count, bytes
            p      = p + 2 + vec[p];      // const count, consts, expected
            ntests = ntests + 1;
        end
        if (ntests == 0) begin
            $display("no test records found in dv/bc_core_vectors.hex");
            stop_run();
        end
        cycle_limit = CYCLES_PER_TEST * ntests;

        p = 0;
        for (int t = 0; t < ntests; t++) begin
            @(posedge clk);
            #1;
            rearm = 1'b1;
            num      = vec[p];
            cur_name = test_name(num);
            n        = vec[p + 1];
            p        = p + 2;
            for (int i = 0; i < 256; i++) begin
                prog[i] = (i < n) ? vec[p + i][7:0] : 8'h00;
            end
            p = p + n;
            n = vec[p];
            p = p + 1;
            for (int i = 0; i < 256; i++) begin
                pool[i] = (i < n) ? vec[p + i] : 32'h0;
            end
            p        = p + n;
            expected = vec[p];
            p        = p + 1;
            @(posedge clk);
            #1;
            rearm = 1'b0;
            @(negedge clk);  // reset is high by now
            while (rst) @(negedge clk);
            // outputs straight out of reset, nothing executed yet
            check_value({cur_name, " reset pc"}, 32'h0, {16'h0, program_counter});
            check_value({cur_name, " reset dataindex"}, 32'h0, {16'h0, dataindex});
            check_value({cur_name, " reset result"}, 32'h0, result);
            check_value({cur_name, " reset halted"}, 32'h0, {31'h0, halted});
            while (!halted) @(negedge clk);
            check_value({cur_name, " result"}, expected, result);
            $display("%s done, result %08h", cur_name, result);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- dv/bc_core_vectors.hex
// test_no byte_count program_bytes... const_count const_words... expected_result
// all fields hex, one test per line, a test number of 0 ends the list
// push 0, 127+5, minus -128, 0 minus that, plus 1
1 c 03 10 7f 08 60 10 80 64 64 04 60 ac 0 fffffefd
// store 1, 42, 3 into locals 0, 1, 5 then (l0 - l1) - l5
2 13 04 36 00 10 2a 36 01 06 36 05 15 00 15 01 64 15 05 64 ac 0 ffffffd4
// ldc 0 plus ldc 1
3 6 12 00 12 01 60 ac 2 12345678 0fedcba9 22222221
// sum of 5 down to 1 with ifeq and goto
4 1e 08 36 00 03 36 01 15 00 99 00 13 15 01 15 00 60 36 01 15 00 04 64 36 00 a7 ff ee 15 01 ac 0 f
// sub(50, 8) plus caller locals 7 and 9
5 1c 10 07 36 00 10 09 36 01 10 32 10 08 b8 00 00 15 00 60 15 01 60 ac 15 00 15 01 64 ac 1 00160202 3a
// f(20) calls g(20, 3) and adds 1
6 16 10 14 b8 00 00 ac 15 00 10 03 b8 00 01 04 60 ac 15 00 15 01 64 ac 2 00060101 00100202 12
0

//--- compile.f
rtl/bc_isa_pkg.sv
rtl/bc_frame_pkg.sv
rtl/store_if.sv
rtl/local_var_array.sv
rtl/lifo_stack.sv
rtl/exec_unit.sv
rtl/method_sequencer.sv
rtl/bc_core.sv
dv/tb_clock.sv
dv/bc_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= bc_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the regression, check $(LOG)"
	@echo "make clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
